//--- dv/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam int NP          = mem_pkg::NUM_PORTS;
    localparam int CREDITS     = mem_pkg::PORT_CREDITS;
    localparam int RD_STEPS    = 4;                    // 3 cycles edge to edge plus half a cycle each side
    localparam int DRAIN_MAX   = 200;                  // cycles before a drain gives up
    localparam int BURST       = 24;                   // writes per port in the credit burst
    localparam int RAND_REQS   = 300;
    localparam int WIN         = 8;                    // words per port in random traffic
    localparam int WATCHDOG_NS = 400 * 4 * 100 + 40000;

    logic                       clk;
    logic                       arst_n;
    logic [NP-1:0]              port_req_valid;
    mem_pkg::mem_req_t [NP-1:0] port_req;
    logic [NP-1:0]              credit_return;
    logic                       rsp_valid;
    mem_pkg::mem_rsp_t          rsp;

    // requester model and scoreboard
    int             credits [NP];
    int             req_cnt [NP];
    int             ret_cnt [NP];
    mem_pkg::word_t ref_mem [mem_pkg::ram_addr_t];    // board memory as the tb sees it
    mem_pkg::word_t exp_rd  [NP][$];                   // reads in flight, per port
    int             exp_cyc [NP][$];                   // step each read was driven
    int             rsp_log [$];                       // ports in response order
    int             cyc;
    int             last_lat;
    int             errors;
    int             checks;
    int             tests;
    int             seed;

    mem_subsys dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .port_req_valid (port_req_valid),
        .port_req       (port_req),
        .credit_return  (credit_return),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                             // 100 ns period

    function automatic mem_pkg::word_t merge_bytes(mem_pkg::word_t old_w,
                                                   mem_pkg::word_t new_w,
                                                   mem_pkg::mask_t be);
        mem_pkg::word_t res;
        res = old_w;
        for (int i = 0; i < mem_pkg::MASK_W; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];       // enabled byte only
            end
        end
        return res;
    endfunction

    function automatic mem_pkg::mem_req_t make_req(logic we, int addr, mem_pkg::mask_t be,
                                                   mem_pkg::word_t data);
        mem_pkg::mem_req_t r;
        r.we    = we;
        r.addr  = mem_pkg::ram_addr_t'(addr);
        r.be    = be;
        r.wdata = data;
        return r;
    endfunction

    task automatic flag_mismatch(string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic raise_error(string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // credits back and read responses seen mid cycle
    task automatic sample_outputs();
        int             p;
        int             c;
        mem_pkg::word_t exp_w;
        for (p = 0; p < NP; p++) begin
            if (credit_return[p]) begin
                credits[p]++;
                ret_cnt[p]++;
                checks++;
                if (credits[p] > CREDITS) begin
                    raise_error($sformatf("port %0d holds more than %0d credits", p, CREDITS));
                end
            end
        end
        if (rsp_valid) begin
            p = int'(rsp.port);
            rsp_log.push_back(p);
            checks++;
            if (exp_rd[p].size() == 0) begin
                raise_error($sformatf("response on port %0d with no read outstanding", p));
            end else begin
                exp_w    = exp_rd[p].pop_front();
                c        = exp_cyc[p].pop_front();
                last_lat = cyc - c;
                if (rsp.rdata !== exp_w) begin
                    flag_mismatch($sformatf("port %0d read %h, expected %h", p, rsp.rdata, exp_w));
                end
            end
        end
    endtask

    task automatic next_edge();
        @(negedge clk);
        cyc++;
        sample_outputs();
        port_req_valid = '0;                           // valid lasts one cycle
    endtask

    // spend a credit, update the reference, queue the expected read
    task automatic drive(int p, mem_pkg::mem_req_t r);
        mem_pkg::word_t old_w;
        checks++;
        if (credits[p] <= 0) begin
            raise_error($sformatf("port %0d would drive a request without a credit", p));
        end else begin
            credits[p]--;
            req_cnt[p]++;
            port_req_valid[p] = 1'b1;
            port_req[p]       = r;
            if (r.we) begin
                old_w = ref_mem.exists(r.addr) ? ref_mem[r.addr] : '0;
                ref_mem[r.addr] = merge_bytes(old_w, r.wdata, r.be);
            end else begin
                exp_rd[p].push_back(ref_mem[r.addr]);
                exp_cyc[p].push_back(cyc);
            end
        end
    endtask

    task automatic send(int p, mem_pkg::mem_req_t r);
        int waited;
        waited = 0;
        next_edge();
        while (credits[p] == 0 && waited < DRAIN_MAX) begin
            next_edge();
            waited++;
        end
        if (credits[p] == 0) begin
            raise_error($sformatf("no credit came back on port %0d", p));
        end else begin
            drive(p, r);
        end
    endtask

    // done when every read answered and every credit home
    task automatic wait_drain();
        int waited;
        bit busy;
        waited = 0;
        busy   = 1'b1;
        while (busy && waited < DRAIN_MAX) begin
            next_edge();
            waited++;
            busy = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (exp_rd[p].size() != 0 || credits[p] != CREDITS) begin
                    busy = 1'b1;
                end
            end
        end
        if (busy) begin
            raise_error("reads or credits still outstanding when the drain timed out");
        end
    endtask

    task automatic apply_reset();
        arst_n         = 1'b0;
        port_req_valid = '0;
        port_req       = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        for (int p = 0; p < NP; p++) begin
            credits[p] = CREDITS;                      // full credit after reset
            req_cnt[p] = 0;
            ret_cnt[p] = 0;
            exp_rd[p].delete();
            exp_cyc[p].delete();
        end
        rsp_log.delete();
    endtask

    task automatic end_test(string name, int start);
        tests++;
        if (errors == start) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s failed, %0d errors", name, errors - start);
        end
    endtask

    task automatic single_port_rw();
        int start;
        start = errors;
        send(0, make_req(1'b1, 'h10, 4'hf, $urandom));
        wait_drain();
        rsp_log.delete();
        send(0, make_req(1'b0, 'h10, 4'h0, '0));     // read from an idle subsystem
        wait_drain();
        checks++;
        if (rsp_log.size() != 1 || rsp_log[0] != 0) begin
            raise_error("read on port 0 did not return one port 0 response");
        end else if (last_lat != RD_STEPS) begin
            flag_mismatch($sformatf("read took %0d cycles, expected 3", last_lat - 1));
        end
        end_test("single_port_rw", start);
    endtask

    task automatic byte_merge();
        int start;
        start = errors;
        rsp_log.delete();
        send(0, make_req(1'b1, 'h20, 4'b1111, $urandom));
        send(0, make_req(1'b1, 'h20, 4'b0001, $urandom));
        send(0, make_req(1'b1, 'h20, 4'b0100, $urandom));
        send(0, make_req(1'b1, 'h20, 4'b1010, $urandom));
        send(0, make_req(1'b0, 'h20, 4'b0000, '0));
        wait_drain();
        checks++;
        if (rsp_log.size() != 1) begin
            raise_error("merged word read did not return exactly one response");
        end
        end_test("byte_merge", start);
    endtask

    task automatic round_robin();
        int start;
        apply_reset();                                 // port 0 preferred again
        start = errors;
        next_edge();
        drive(0, make_req(1'b0, 'h10, 4'h0, '0));
        drive(1, make_req(1'b0, 'h20, 4'h0, '0));
        next_edge();
        drive(0, make_req(1'b0, 'h20, 4'h0, '0));
        drive(1, make_req(1'b0, 'h10, 4'h0, '0));
        wait_drain();
        checks++;
        if (rsp_log.size() != 4) begin
            raise_error($sformatf("expected 4 responses, got %0d", rsp_log.size()));
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (rsp_log[i] != i % 2) begin
                    flag_mismatch($sformatf("response %0d from port %0d, expected port %0d",
                                            i, rsp_log[i], i % 2));
                end
            end
        end
        end_test("round_robin", start);
    endtask

    task automatic credit_accounting();
        int start;
        int guard;
        int sent [NP];
        start = errors;
        guard = 0;
        for (int p = 0; p < NP; p++) begin
            sent[p]    = 0;
            req_cnt[p] = 0;
            ret_cnt[p] = 0;
        end
        while ((sent[0] < BURST || sent[1] < BURST) && guard < BURST * 8) begin
            next_edge();
            guard++;
            for (int p = 0; p < NP; p++) begin
                if (sent[p] < BURST && credits[p] > 0) begin
                    drive(p, make_req(1'b1, 'h40 + 'h40 * p + sent[p], 4'hf, $urandom));
                    sent[p]++;
                end
            end
        end
        wait_drain();
        for (int p = 0; p < NP; p++) begin
            checks++;
            if (sent[p] != BURST) begin
                raise_error($sformatf("port %0d sent only %0d of its burst", p, sent[p]));
            end else if (ret_cnt[p] != req_cnt[p] || credits[p] != CREDITS) begin
                flag_mismatch($sformatf("port %0d: %0d requests, %0d returns, %0d credits",
                                        p, req_cnt[p], ret_cnt[p], credits[p]));
            end
        end
        end_test("credit_accounting", start);
    endtask

    task automatic random_traffic();
        int   start;
        int   issued;
        int   guard;
        int   p;
        logic we;
        start = errors;
        // each port owns its own window, so per-port order fixes every read
        for (int a = 0; a < WIN; a++) begin
            for (int q = 0; q < NP; q++) begin
                send(q, make_req(1'b1, 'h300 + q * WIN + a, 4'hf, $urandom));
            end
        end
        issued = 0;
        guard  = 0;
        while (issued < RAND_REQS && guard < RAND_REQS * 8) begin
            next_edge();
            guard++;
            p = int'($urandom % NP);
            if (credits[p] > 0) begin
                we = ($urandom % 2) == 1;
                drive(p, make_req(we, 'h300 + p * WIN + int'($urandom % WIN),
                                  mem_pkg::mask_t'($urandom), $urandom));
                issued++;
            end
        end
        wait_drain();                                  // catches any missing response
        checks++;
        if (issued != RAND_REQS) begin
            raise_error($sformatf("only %0d of %0d random requests went out", issued, RAND_REQS));
        end
        end_test("random_traffic", start);
    endtask

    initial begin
        arst_n         = 1'b0;
        port_req_valid = '0;
        port_req       = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        cyc            = 0;
        last_lat       = 0;
        seed           = $urandom(20);                 // one seed for the whole run
        apply_reset();
        single_port_rw();
        byte_merge();
        round_robin();
        credit_accounting();
        random_traffic();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // about 400 requests at 4 cycles each plus margin
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run timed out after %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- hdl/fake_sram.sv
`timescale 1ns/10ps

module fake_sram (
    input  logic               clk,
    inout  mem_pkg::word_t     ram_data,       // shared with the controller
    input  mem_pkg::ram_addr_t ram_addr,       // word address
    input  mem_pkg::mask_t     ram_be_n,       // low active byte enables
    input  logic               ram_ce_n,       // low active chip select
    input  logic               ram_oe_n,       // low active output enable
    input  logic               ram_we_n        // low active write enable
);

    // word addressed array
    mem_pkg::word_t sram_mem [mem_pkg::RAM_DEPTH];
    mem_pkg::word_t data_out;
    logic           rd_en;
    logic           wr_en;

    assign rd_en = !ram_ce_n && !ram_oe_n && ram_we_n;
    assign wr_en = !ram_ce_n && !ram_we_n && ram_oe_n;

    // async read path
    always_comb begin
        if (rd_en) begin
            data_out = sram_mem[ram_addr];
        end else begin
            data_out = mem_pkg::HIGH_WORD;     // deselected or not reading
        end
    end

    // drive only during a read and float otherwise
    assign ram_data = rd_en ? data_out : 'z;

    // write enabled bytes on the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < mem_pkg::MASK_W; i++) begin
                if (!ram_be_n[i]) begin
                    sram_mem[ram_addr][8*i +: 8] <= ram_data[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- hdl/mem_pkg.sv
package mem_pkg;

    // board sram geometry
    localparam int DATA_W    = 32;             // sram word width
    localparam int ADDR_W    = 20;             // word address, 1 mword
    localparam int MASK_W    = DATA_W / 8;     // one enable per byte
    localparam int RAM_DEPTH = 1 << ADDR_W;

    // requester side
    localparam int NUM_PORTS    = 2;           // fetch + load/store
    localparam int PORT_CREDITS = 2;           // queue depth == initial credits
    localparam int QPTR_W       = (PORT_CREDITS > 1) ? $clog2(PORT_CREDITS) : 1;
    localparam int QCNT_W       = $clog2(PORT_CREDITS + 1);

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] ram_addr_t;
    typedef logic [MASK_W-1:0] mask_t;         // active high in requests
    typedef logic [$clog2(NUM_PORTS)-1:0] port_id_t;

    // model output while deselected
    localparam word_t HIGH_WORD = '1;

    // one word request, as queued and granted
    typedef struct packed {
        logic      we;                         // 1 = write
        ram_addr_t addr;
        mask_t     be;
        word_t     wdata;
    } mem_req_t;

    // read response, writes get only a credit back
    typedef struct packed {
        port_id_t port;                        // who asked
        word_t    rdata;
    } mem_rsp_t;

endpackage

//--- hdl/mem_subsys.sv
`timescale 1ns/10ps

module mem_subsys (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic [mem_pkg::NUM_PORTS-1:0]               port_req_valid,
    input  mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0]  port_req,
    output logic [mem_pkg::NUM_PORTS-1:0]               credit_return,
    output logic                                        rsp_valid,
    output mem_pkg::mem_rsp_t                           rsp
);

    // queue heads toward the arbiter
    logic [mem_pkg::NUM_PORTS-1:0]              head_valid;
    mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0] head;
    logic [mem_pkg::NUM_PORTS-1:0]              pop;

    // arbiter to controller
    logic               grant_valid;
    mem_pkg::mem_req_t  grant;
    mem_pkg::port_id_t  grant_port;
    logic               ctrl_idle;

    // board sram pins
    mem_pkg::ram_addr_t ram_addr;
    mem_pkg::mask_t     ram_be_n;
    logic               ram_ce_n;
    logic               ram_oe_n;
    logic               ram_we_n;
    wire mem_pkg::word_t ram_data;             // two tristate drivers

    // one credit queue per port, 0 = fetch, 1 = load/store
    for (genvar p = 0; p < mem_pkg::NUM_PORTS; p++) begin : g_port
        req_queue u_queue (
            .clk           (clk),
            .arst_n        (arst_n),
            .push          (port_req_valid[p]),
            .push_req      (port_req[p]),
            .head_valid    (head_valid[p]),
            .head          (head[p]),
            .pop           (pop[p]),
            .credit_return (credit_return[p])
        );
    end

    port_arbiter u_arb (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .head        (head),
        .pop         (pop),
        .ctrl_idle   (ctrl_idle),
        .grant_valid (grant_valid),
        .grant       (grant),
        .grant_port  (grant_port)
    );

    sram_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .grant_valid (grant_valid),
        .grant       (grant),
        .grant_port  (grant_port),
        .ctrl_idle   (ctrl_idle),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .ram_addr    (ram_addr),
        .ram_be_n    (ram_be_n),
        .ram_ce_n    (ram_ce_n),
        .ram_oe_n    (ram_oe_n),
        .ram_we_n    (ram_we_n),
        .ram_data    (ram_data)
    );

    // stands in for the external chip
    fake_sram u_sram (
        .clk      (clk),
        .ram_data (ram_data),
        .ram_addr (ram_addr),
        .ram_be_n (ram_be_n),
        .ram_ce_n (ram_ce_n),
        .ram_oe_n (ram_oe_n),
        .ram_we_n (ram_we_n)
    );

endmodule

//--- hdl/port_arbiter.sv
`timescale 1ns/10ps

module port_arbiter (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic [mem_pkg::NUM_PORTS-1:0]               head_valid,
    input  mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0]  head,
    output logic [mem_pkg::NUM_PORTS-1:0]               pop,
    input  logic                                        ctrl_idle,
    output logic                                        grant_valid,
    output mem_pkg::mem_req_t                           grant,
    output mem_pkg::port_id_t                           grant_port
);

    mem_pkg::port_id_t last_grant;  // winner of the last transfer
    mem_pkg::port_id_t sel;
    logic              xfer;

    // search starts one past the last winner
    always_comb begin
        int  idx;
        logic found;
        sel   = last_grant;
        found = 1'b0;
        for (int k = 1; k <= mem_pkg::NUM_PORTS; k++) begin
            idx = (int'(last_grant) + k) % mem_pkg::NUM_PORTS;
            if (!found && head_valid[idx]) begin
                sel   = mem_pkg::port_id_t'(idx);
                found = 1'b1;
            end
        end
    end

    assign grant_valid = |head_valid;          // any head waiting
    assign grant       = head[sel];
    assign grant_port  = sel;
    assign xfer        = grant_valid && ctrl_idle;  // controller latches this cycle

    // pop only the winner, only on a transfer
    always_comb begin
        pop = '0;
        if (xfer) begin
            pop[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // last = highest port, so port 0 goes first
            last_grant <= mem_pkg::port_id_t'(mem_pkg::NUM_PORTS - 1);
        end else if (xfer) begin
            last_grant <= sel;
        end
    end

endmodule

//--- hdl/req_queue.sv
`timescale 1ns/10ps

module req_queue (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,           // requester spent a credit
    input  mem_pkg::mem_req_t  push_req,
    output logic               head_valid,
    output mem_pkg::mem_req_t  head,
    input  logic               pop,            // arbiter took the head
    output logic               credit_return   // one pulse per pop
);

    // storage, no reset on payload
    mem_pkg::mem_req_t             q_mem [mem_pkg::PORT_CREDITS];
    logic [mem_pkg::QPTR_W-1:0]    wr_ptr;
    logic [mem_pkg::QPTR_W-1:0]    rd_ptr;
    logic [mem_pkg::QCNT_W-1:0]    count;

    localparam logic [mem_pkg::QPTR_W-1:0] LAST_PTR =
        mem_pkg::QPTR_W'(mem_pkg::PORT_CREDITS - 1);

    assign head_valid = (count != '0);
    assign head       = q_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            q_mem[wr_ptr] <= push_req;             // credits keep this from overrunning
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;                  // slot freed, hand the credit back
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/sram_ctrl.sv
`timescale 1ns/10ps

module sram_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               grant_valid,
    input  mem_pkg::mem_req_t  grant,
    input  mem_pkg::port_id_t  grant_port,
    output logic               ctrl_idle,      // can take a grant this cycle
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp,
    output mem_pkg::ram_addr_t ram_addr,
    output mem_pkg::mask_t     ram_be_n,
    output logic               ram_ce_n,
    output logic               ram_oe_n,
    output logic               ram_we_n,
    inout  mem_pkg::word_t     ram_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,                             // first access cycle
        ST_HOLD                                // second, read sampled at its end
    } state_t;

    state_t            state;
    mem_pkg::mem_req_t cur_req;                // latched grant
    mem_pkg::port_id_t cur_port;
    logic              data_oe;                // we own the data bus
    logic              accept;

    // hold overlaps the next grant, so one access every 2 cycles
    assign ctrl_idle = (state != ST_STROBE);
    assign accept    = grant_valid && ctrl_idle;

    // pins straight off the latched request
    assign ram_addr = cur_req.addr;
    assign ram_be_n = ~cur_req.be;             // active low on the board
    assign ram_data = data_oe ? cur_req.wdata : 'z;

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req  <= grant;
            cur_port <= grant_port;
        end
        if (state == ST_HOLD && !cur_req.we) begin
            rsp.port  <= cur_port;
            rsp.rdata <= ram_data;             // sram driving since strobe
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            ram_ce_n  <= 1'b1;
            ram_oe_n  <= 1'b1;
            ram_we_n  <= 1'b1;
            data_oe   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;                 // single cycle pulse
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state    <= ST_STROBE;
                        ram_ce_n <= 1'b0;
                        ram_oe_n <= grant.we;  // reads enable output
                        ram_we_n <= !grant.we;
                        data_oe  <= grant.we;
                    end
                end
                ST_STROBE: begin
                    state <= ST_HOLD;
                    if (cur_req.we) begin
                        ram_we_n <= 1'b1;      // write committed at this edge
                    end
                end
                ST_HOLD: begin
                    if (!cur_req.we) begin
                        rsp_valid <= 1'b1;
                    end
                    if (accept) begin
                        // back to back, straight into the next strobe
                        state    <= ST_STROBE;
                        ram_ce_n <= 1'b0;
                        ram_oe_n <= grant.we;
                        ram_we_n <= !grant.we;
                        data_oe  <= grant.we;
                    end else begin
                        state    <= ST_IDLE;
                        ram_ce_n <= 1'b1;
                        ram_oe_n <= 1'b1;
                        ram_we_n <= 1'b1;
                        data_oe  <= 1'b0;  // release the bus
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    ram_ce_n <= 1'b1;
                    ram_oe_n <= 1'b1;
                    ram_we_n <= 1'b1;
                    data_oe  <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- mem_subsys.f
hdl/mem_pkg.sv
hdl/req_queue.sv
hdl/port_arbiter.sv
hdl/sram_ctrl.sv
hdl/fake_sram.sv
hdl/mem_subsys.sv
dv/tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mem_subsys testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_mem_subsys
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
    -f mem_subsys.f \
    --top-module tb_mem_subsys \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
    exit 0
fi
echo "simulation reported failure"
exit 1
